//--- build.f
source/isa_pkg.sv
source/rob_pkg.sv
source/rob_buffer.sv
source/commit_unit.sv
source/commit_fsm.sv
source/store_wait_timer.sv
source/arch_regfile.sv
source/ooo_retire_top.sv
sim/ooo_retire_props.sv
sim/ooo_retire_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run the retirement testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module ooo_retire_tb -f build.f -o sim_exe
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/sim_exe +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" <<< "$output"; then
    exit 0
fi
exit 1

//--- sim/ooo_retire_props.sv
/*
 * Concurrent checks on the commit FSM, attached to commit_fsm with bind.
 */
`timescale 1ns/1ns

module ooo_retire_props (
    input logic                   clk,
    input logic                   arst_n,
    input rob_pkg::commit_state_e state,
    input logic                   flush,
    input logic                   dequeue,
    input logic                   store_blocked
);
    import rob_pkg::*;

    // Number of assertion failures so far
    int fail_count = 0;

    // The buffer is empty once the flush cycle ends
    flush_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> (!flush && !dequeue))
    else begin
        fail_count++;
        $error("flush lasted more than one cycle or an entry retired right after it");
    end

    // Retirement is frozen during the flush cycle
    no_commit_in_flush: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ST_FLUSH) |-> !dequeue)
    else begin
        fail_count++;
        $error("an entry retired in the flush state");
    end

    // A blocked store keeps the head until it retires
    blocked_store_holds: assert property (@(posedge clk) disable iff (!arst_n)
        (store_blocked && !flush) |=> (store_blocked || dequeue))
    else begin
        fail_count++;
        $error("a blocked store left the head without retiring");
    end

endmodule

bind commit_fsm ooo_retire_props fsm_props_inst (
    .clk(clk),
    .arst_n(arst_n),
    .state(state),
    .flush(flush),
    .dequeue(dequeue),
    .store_blocked(store_blocked)
);

//--- sim/ooo_retire_tb.sv
/*
 * Testbench for the retirement subsystem. Drives allocation, completion and
 * store_done, and checks each retirement against an in-order model of the buffer.
 */
`timescale 1ns/1ns

module ooo_retire_tb;
    import isa_pkg::*;

    localparam int ROB_DEPTH     = 16;
    localparam int STORE_TIMEOUT = 8;
    localparam int TAG_W         = $clog2(ROB_DEPTH);
    localparam int WAIT_LIMIT    = 200;

    logic                  clk;
    logic                  arst_n;
    logic                  alloc_valid;
    itype_e                alloc_itype;
    logic [XLEN-1:0]       alloc_dest;
    logic                  alloc_pred;
    logic [TAG_W-1:0]      alloc_tag;
    logic                  rob_full;
    logic                  cmpl_valid;
    logic [TAG_W-1:0]      cmpl_tag;
    logic [XLEN-1:0]       cmpl_value;
    logic                  cmpl_result;
    logic                  store_done;
    logic [REG_ADDR_W-1:0] rf_raddr;
    logic [XLEN-1:0]       rf_rdata;
    logic                  commit_valid;
    logic                  reg_write;
    logic [TAG_W-1:0]      commit_rob;
    logic [REG_ADDR_W-1:0] commit_rd;
    logic [XLEN-1:0]       write_data;
    logic [XLEN-1:0]       committed_pc;
    logic [XLEN-1:0]       commit_imm_se;
    logic                  commit_is_branch;
    logic                  commit_prediction;
    logic                  commit_result;
    logic                  flush;
    logic                  store_timeout;

    // Model entries by tag; order_q keeps tags in program order
    itype_e          e_kind   [ROB_DEPTH];
    logic [XLEN-1:0] e_dest   [ROB_DEPTH];
    logic [XLEN-1:0] e_value  [ROB_DEPTH];
    logic            e_pred   [ROB_DEPTH];
    logic            e_result [ROB_DEPTH];
    int              order_q  [$];
    int              pending_q[$];
    logic [XLEN-1:0] exp_reg  [2**REG_ADDR_W];
    logic            flush_due = 1'b0;
    logic [15:0]     lfsr      = 16'd16085;
    int              errors    = 0;
    int              retired   = 0;

    ooo_retire_top #(
        .ROB_DEPTH(ROB_DEPTH),
        .STORE_TIMEOUT(STORE_TIMEOUT)
    ) ooo_retire_top_inst (.*);

    always #10 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (exp === got) else begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("ERROR at %0t ns: %s", $time, what);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic allocate(input itype_e kind, input logic [XLEN-1:0] dest,
                            input logic pred, input logic result, output int tag);
        tick();
        require(!rob_full, "allocation attempted while the buffer was full");
        tag           = int'(alloc_tag);
        alloc_valid   = 1'b1;
        alloc_itype   = kind;
        alloc_dest    = dest;
        alloc_pred    = pred;
        e_kind[tag]   = kind;
        e_dest[tag]   = dest;
        e_value[tag]  = rand_bits(32);
        e_pred[tag]   = pred;
        e_result[tag] = result;
        order_q.push_back(tag);
        tick();
        alloc_valid = 1'b0;
    endtask

    task automatic complete(input int tag);
        tick();
        cmpl_valid  = 1'b1;
        cmpl_tag    = TAG_W'(tag);
        cmpl_value  = e_value[tag];
        cmpl_result = e_result[tag];
        tick();
        cmpl_valid = 1'b0;
    endtask

    // Completes every pending tag in a shuffled order
    task automatic complete_shuffled();
        int j;
        int t;
        for (int i = pending_q.size() - 1; i > 0; i--) begin
            j            = int'(rand_bits(4)) % (i + 1);
            t            = pending_q[i];
            pending_q[i] = pending_q[j];
            pending_q[j] = t;
        end
        for (int i = 0; i < pending_q.size(); i++) begin
            complete(pending_q[i]);
        end
        pending_q.delete();
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (order_q.size() != 0 && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        require(order_q.size() == 0, "timeout waiting for the buffer to drain");
    endtask

    // Retirement checker, samples at the falling edge
    task automatic watch_retirement();
        int               t;
        logic [REG_ADDR_W-1:0] rd;
        forever begin
            @(negedge clk);
            if (arst_n) begin
                compare_value("flush", 32'(flush_due), 32'(flush));
                flush_due = 1'b0;
                if (commit_valid && order_q.size() == 0) begin
                    require(1'b0, "an entry retired that was flushed or never allocated");
                end else if (commit_valid) begin
                    t  = order_q.pop_front();
                    rd = e_dest[t][REG_ADDR_W-1:0];
                    retired++;
                    compare_value("commit_rob", 32'(t), 32'(commit_rob));
                    compare_value("commit_is_branch", 32'(e_kind[t] == ITYPE_BRANCH),
                                  32'(commit_is_branch));
                    compare_value("reg_write", 32'(e_kind[t] == ITYPE_ALU), 32'(reg_write));
                    if (e_kind[t] == ITYPE_ALU) begin
                        compare_value("commit_rd", 32'(rd), 32'(commit_rd));
                        compare_value("write_data", e_value[t], write_data);
                        if (rd != '0) begin
                            exp_reg[rd] = e_value[t];
                        end
                    end else begin
                        compare_value("committed_pc", e_dest[t], committed_pc);
                    end
                    if (e_kind[t] == ITYPE_STORE) begin
                        require(store_done, "store retired while store_done was low");
                    end
                    if (e_kind[t] == ITYPE_BRANCH) begin
                        compare_value("commit_prediction", 32'(e_pred[t]),
                                      32'(commit_prediction));
                        compare_value("commit_result", 32'(e_result[t]), 32'(commit_result));
                        compare_value("commit_imm_se", e_value[t], commit_imm_se);
                        // Younger entries die with the mispredicted branch
                        if (e_pred[t] != e_result[t]) begin
                            flush_due = 1'b1;
                            order_q.delete();
                        end
                    end
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int tag;
        int first;
        int n;
        int prop_fails;
        clk         = 1'b0;
        arst_n      = 1'b0;
        alloc_valid = 1'b0;
        alloc_itype = ITYPE_ALU;
        alloc_dest  = '0;
        alloc_pred  = 1'b0;
        cmpl_valid  = 1'b0;
        cmpl_tag    = '0;
        cmpl_value  = '0;
        cmpl_result = 1'b0;
        store_done  = 1'b0;
        rf_raddr    = '0;
        for (int r = 0; r < 2**REG_ADDR_W; r++) begin
            exp_reg[r] = '0;
        end
        fork
            watch_retirement();
        join_none
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        compare_value("commit_valid", 32'd0, 32'(commit_valid));
        compare_value("reg_write", 32'd0, 32'(reg_write));
        compare_value("store_timeout", 32'd0, 32'(store_timeout));
        compare_value("rob_full", 32'd0, 32'(rob_full));

        // Register writes, completed out of order, register 0 included
        for (int i = 0; i < 6; i++) begin
            allocate(ITYPE_ALU, (i < 5) ? XLEN'(i + 1) : '0, 1'b0, 1'b0, tag);
            pending_q.push_back(tag);
        end
        complete_shuffled();
        drain();
        for (int r = 0; r < 6; r++) begin
            tick();
            rf_raddr = REG_ADDR_W'(r);
            @(negedge clk);
            compare_value("rf_rdata", exp_reg[r], rf_rdata);
        end

        // Ready store holds the head until store_done
        allocate(ITYPE_STORE, 32'h0000_0100, 1'b0, 1'b0, first);
        allocate(ITYPE_ALU, 32'd7, 1'b0, 1'b0, tag);
        complete(tag);
        complete(first);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            require(!commit_valid, "retirement while the head store waited");
        end
        tick();
        store_done = 1'b1;
        @(negedge clk);
        require(commit_valid, "store missed the first cycle of store_done");
        tick();
        store_done = 1'b0;
        drain();

        // Correctly predicted branch
        allocate(ITYPE_BRANCH, 32'h0000_0200, 1'b1, 1'b1, first);
        allocate(ITYPE_ALU, 32'd8, 1'b0, 1'b0, tag);
        complete(tag);
        complete(first);
        drain();

        // Mispredicted branch with three younger entries
        allocate(ITYPE_BRANCH, 32'h0000_0300, 1'b0, 1'b1, first);
        for (int i = 0; i < 3; i++) begin
            allocate(ITYPE_ALU, XLEN'(9 + i), 1'b0, 1'b0, tag);
            pending_q.push_back(tag);
        end
        complete_shuffled();
        complete(first);
        n = 0;
        while (!flush && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        require(flush, "timeout waiting for flush after a misprediction");
        alloc_valid = 1'b1;
        alloc_itype = ITYPE_ALU;
        alloc_dest  = 32'd20;
        tick();
        alloc_valid = 1'b0;
        compare_value("rob_full", 32'd0, 32'(rob_full));
        allocate(ITYPE_ALU, 32'd12, 1'b0, 1'b0, tag);
        compare_value("alloc_tag", 32'd0, 32'(tag));
        complete(tag);
        drain();

        // Back-pressure
        for (int i = 0; i < ROB_DEPTH; i++) begin
            allocate(ITYPE_ALU, XLEN'(rand_bits(REG_ADDR_W)), 1'b0, 1'b0, tag);
            pending_q.push_back(tag);
        end
        require(rob_full, "rob_full low after a full set of allocations");
        first       = int'(alloc_tag);
        alloc_valid = 1'b1;
        tick();
        alloc_valid = 1'b0;
        require(rob_full, "rob_full dropped after an allocation into a full buffer");
        compare_value("alloc_tag", 32'(first), 32'(alloc_tag));
        complete_shuffled();
        drain();
        require(!rob_full, "rob_full still high after draining");

        // Store timeout is sticky
        compare_value("store_timeout", 32'd0, 32'(store_timeout));
        allocate(ITYPE_STORE, 32'h0000_0400, 1'b0, 1'b0, first);
        complete(first);
        n = 0;
        while (!store_timeout && n < STORE_TIMEOUT + 10) begin
            tick();
            n++;
        end
        require(store_timeout, "store_timeout did not rise for a blocked store");
        require(n >= STORE_TIMEOUT, "store_timeout rose before the limit");
        tick();
        store_done = 1'b1;
        tick();
        store_done = 1'b0;
        drain();
        require(store_timeout, "store_timeout cleared after the store retired");

        tick();
        prop_fails = ooo_retire_top_inst.commit_fsm_inst.fsm_props_inst.fail_count;
        $display("Check errors: %0d, property failures: %0d, entries retired: %0d",
                 errors, prop_fails, retired);
        if (errors == 0 && prop_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- source/arch_regfile.sv
/*
 * Architectural register file. One write port from commit, one
 * combinational read port; register 0 always reads zero.
 */
`timescale 1ns/1ns

module arch_regfile (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           reg_write,
    input  logic [isa_pkg::REG_ADDR_W-1:0] commit_rd,
    input  logic [isa_pkg::XLEN-1:0]       write_data,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rf_raddr,
    output logic [isa_pkg::XLEN-1:0]       rf_rdata
);
    import isa_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && (commit_rd != '0)) begin
            regs[commit_rd] <= write_data;
        end
    end

    assign rf_rdata = (rf_raddr == '0) ? '0 : regs[rf_raddr];

endmodule

//--- source/commit_fsm.sv
/*
 * Sequences retirement: normal run, waiting on a store at the head,
 * and the single flush cycle after a mispredicted branch.
 */
`timescale 1ns/1ns

module commit_fsm (
    input  logic clk,
    input  logic arst_n,
    input  logic dequeue,
    input  logic commit_is_branch,
    input  logic commit_prediction,
    input  logic commit_result,
    input  logic store_blocked,
    output logic commit_en,
    output logic flush,
    output logic timer_run
);
    import rob_pkg::*;

    commit_state_e state;
    commit_state_e state_nxt;
    logic          mispredict;

    assign mispredict = dequeue && commit_is_branch && (commit_prediction != commit_result);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_RUN: begin
                if (mispredict) begin
                    state_nxt = ST_FLUSH;
                end else if (store_blocked) begin
                    state_nxt = ST_STORE_WAIT;
                end
            end
            // Only the waiting store can retire here
            ST_STORE_WAIT: if (dequeue) state_nxt = ST_RUN;
            ST_FLUSH:      state_nxt = ST_RUN;
            default:       state_nxt = ST_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    assign commit_en = (state != ST_FLUSH);
    assign flush     = (state == ST_FLUSH);
    assign timer_run = (state == ST_STORE_WAIT);

endmodule

//--- source/commit_unit.sv
/*
 * Retirement decode of the reorder buffer head. Purely combinational;
 * drives the dequeue strobe and the register file write port.
 */
`timescale 1ns/1ns

module commit_unit #(
    parameter int ROB_DEPTH = 16,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                           commit_en,
    input  logic                           head_ready,
    input  isa_pkg::itype_e                head_itype,
    input  logic [isa_pkg::XLEN-1:0]       head_dest,
    input  logic [isa_pkg::XLEN-1:0]       head_value,
    input  logic                           head_pred,
    input  logic                           head_result,
    input  logic [TAG_W-1:0]               head_tag,
    input  logic                           store_done,
    output logic                           dequeue,
    output logic                           reg_write,
    output logic [TAG_W-1:0]               commit_rob,
    output logic [isa_pkg::REG_ADDR_W-1:0] commit_rd,
    output logic [isa_pkg::XLEN-1:0]       write_data,
    output logic [isa_pkg::XLEN-1:0]       committed_pc,
    output logic [isa_pkg::XLEN-1:0]       commit_imm_se,
    output logic                           commit_is_branch,
    output logic                           commit_prediction,
    output logic                           commit_result,
    output logic                           store_blocked
);
    import isa_pkg::*;

    always_comb begin
        dequeue          = 1'b0;
        reg_write        = 1'b0;
        write_data       = '0;
        commit_is_branch = 1'b0;
        if (commit_en && head_ready) begin
            case (head_itype)
                ITYPE_BRANCH: begin
                    commit_is_branch = 1'b1;
                    dequeue          = 1'b1;
                end
                // Store waits on the memory side
                ITYPE_STORE: dequeue = store_done;
                default: begin
                    reg_write  = 1'b1;
                    write_data = head_value;
                    dequeue    = 1'b1;
                end
            endcase
        end
    end

    assign store_blocked     = head_ready && (head_itype == ITYPE_STORE) && !store_done;
    assign commit_prediction = head_pred;
    assign commit_result     = head_result;
    assign committed_pc      = head_dest;
    assign commit_imm_se     = head_value;
    assign commit_rob        = dequeue ? head_tag : '0;
    assign commit_rd         = dequeue ? head_dest[REG_ADDR_W-1:0] : '0;

endmodule

//--- source/isa_pkg.sv
/*
 * ISA-level constants and the instruction kind carried by each reorder buffer entry.
 * Imported by the retirement blocks and the testbench.
 */
package isa_pkg;

    // Data and pc width
    parameter int XLEN = 32;

    // Architectural register index width
    parameter int REG_ADDR_W = 5;

    // Encoding follows the commit decode of the core
    typedef enum logic [1:0] {
        ITYPE_BRANCH = 2'b00,
        ITYPE_STORE  = 2'b01,
        ITYPE_ALU    = 2'b10
    } itype_e;

endpackage

//--- source/ooo_retire_top.sv
/*
 * Retirement end of the out-of-order core: reorder buffer, commit decode,
 * commit FSM, store-wait timer and architectural register file.
 */
`timescale 1ns/1ns

module ooo_retire_top #(
    parameter int ROB_DEPTH     = 16,
    parameter int STORE_TIMEOUT = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           alloc_valid,
    input  isa_pkg::itype_e                alloc_itype,
    input  logic [isa_pkg::XLEN-1:0]       alloc_dest,
    input  logic                           alloc_pred,
    output logic [TAG_W-1:0]               alloc_tag,
    output logic                           rob_full,
    input  logic                           cmpl_valid,
    input  logic [TAG_W-1:0]               cmpl_tag,
    input  logic [isa_pkg::XLEN-1:0]       cmpl_value,
    input  logic                           cmpl_result,
    input  logic                           store_done,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rf_raddr,
    output logic [isa_pkg::XLEN-1:0]       rf_rdata,
    output logic                           commit_valid,
    output logic                           reg_write,
    output logic [TAG_W-1:0]               commit_rob,
    output logic [isa_pkg::REG_ADDR_W-1:0] commit_rd,
    output logic [isa_pkg::XLEN-1:0]       write_data,
    output logic [isa_pkg::XLEN-1:0]       committed_pc,
    output logic [isa_pkg::XLEN-1:0]       commit_imm_se,
    output logic                           commit_is_branch,
    output logic                           commit_prediction,
    output logic                           commit_result,
    output logic                           flush,
    output logic                           store_timeout
);
    import isa_pkg::*;

    // Head entry toward the commit decode
    logic            head_ready;
    itype_e          head_itype;
    logic [XLEN-1:0] head_dest;
    logic [XLEN-1:0] head_value;
    logic            head_pred;
    logic            head_result;
    logic [TAG_W-1:0] head_tag;

    logic dequeue;
    logic commit_en;
    logic store_blocked;
    logic timer_run;

    assign commit_valid = dequeue;

    rob_buffer #(.ROB_DEPTH(ROB_DEPTH)) rob_buffer_inst (
        .clk, .arst_n, .alloc_valid, .alloc_itype, .alloc_dest, .alloc_pred,
        .cmpl_valid, .cmpl_tag, .cmpl_value, .cmpl_result, .dequeue, .flush,
        .alloc_tag, .rob_full, .head_ready, .head_itype, .head_dest,
        .head_value, .head_pred, .head_result, .head_tag
    );

    commit_unit #(.ROB_DEPTH(ROB_DEPTH)) commit_unit_inst (
        .commit_en, .head_ready, .head_itype, .head_dest, .head_value,
        .head_pred, .head_result, .head_tag, .store_done, .dequeue,
        .reg_write, .commit_rob, .commit_rd, .write_data, .committed_pc,
        .commit_imm_se, .commit_is_branch, .commit_prediction,
        .commit_result, .store_blocked
    );

    commit_fsm commit_fsm_inst (
        .clk, .arst_n, .dequeue, .commit_is_branch, .commit_prediction,
        .commit_result, .store_blocked, .commit_en, .flush, .timer_run
    );

    store_wait_timer #(.STORE_TIMEOUT(STORE_TIMEOUT)) store_wait_timer_inst (
        .clk, .arst_n, .timer_run, .store_timeout
    );

    arch_regfile arch_regfile_inst (
        .clk, .arst_n, .reg_write, .commit_rd, .write_data, .rf_raddr, .rf_rdata
    );

endmodule

//--- source/rob_buffer.sv
/*
 * Circular reorder buffer. Entries are allocated at the tail in program order,
 * completed out of order by tag, and presented at the head for retirement.
 */
`timescale 1ns/1ns

module rob_buffer #(
    parameter int ROB_DEPTH = 16,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     alloc_valid,
    input  isa_pkg::itype_e          alloc_itype,
    input  logic [isa_pkg::XLEN-1:0] alloc_dest,
    input  logic                     alloc_pred,
    input  logic                     cmpl_valid,
    input  logic [TAG_W-1:0]         cmpl_tag,
    input  logic [isa_pkg::XLEN-1:0] cmpl_value,
    input  logic                     cmpl_result,
    input  logic                     dequeue,
    input  logic                     flush,
    output logic [TAG_W-1:0]         alloc_tag,
    output logic                     rob_full,
    output logic                     head_ready,
    output isa_pkg::itype_e          head_itype,
    output logic [isa_pkg::XLEN-1:0] head_dest,
    output logic [isa_pkg::XLEN-1:0] head_value,
    output logic                     head_pred,
    output logic                     head_result,
    output logic [TAG_W-1:0]         head_tag
);
    import isa_pkg::*;

    localparam int COUNT_W = TAG_W + 1;

    // Entry fields
    itype_e            itype_q  [ROB_DEPTH];
    logic [XLEN-1:0]   dest_q   [ROB_DEPTH];
    logic [XLEN-1:0]   value_q  [ROB_DEPTH];
    logic              pred_q   [ROB_DEPTH];
    logic              result_q [ROB_DEPTH];

    logic [ROB_DEPTH-1:0] valid;
    logic [ROB_DEPTH-1:0] ready;
    logic [TAG_W-1:0]     head;
    logic [TAG_W-1:0]     tail;
    logic [COUNT_W-1:0]   count;
    logic                 alloc_do;
    logic                 cmpl_do;

    assign alloc_do = alloc_valid && !rob_full && !flush;
    assign cmpl_do  = cmpl_valid && valid[cmpl_tag] && !flush;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers, occupancy and entry status
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            valid <= '0;
            ready <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            valid <= '0;
            ready <= '0;
        end else begin
            if (alloc_do) begin
                valid[tail] <= 1'b1;
                ready[tail] <= 1'b0;
                tail        <= tail + 1'b1;
            end
            if (cmpl_do) begin
                ready[cmpl_tag] <= 1'b1;
            end
            // Freeing the head overrides a completion to the same slot
            if (dequeue) begin
                valid[head] <= 1'b0;
                ready[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            case ({alloc_do, dequeue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (alloc_do) begin
            itype_q[tail] <= alloc_itype;
            dest_q[tail]  <= alloc_dest;
            pred_q[tail]  <= alloc_pred;
        end
        if (cmpl_do) begin
            value_q[cmpl_tag]  <= cmpl_value;
            result_q[cmpl_tag] <= cmpl_result;
        end
    end

    assign alloc_tag   = tail;
    assign rob_full    = (count == COUNT_W'(ROB_DEPTH));
    assign head_tag    = head;
    assign head_ready  = valid[head] && ready[head];
    assign head_itype  = itype_q[head];
    assign head_dest   = dest_q[head];
    assign head_value  = value_q[head];
    assign head_pred   = pred_q[head];
    assign head_result = result_q[head];

endmodule

//--- source/rob_pkg.sv
/*
 * Types local to the retirement logic of the reorder buffer.
 */
package rob_pkg;

    // Commit sequencing states
    typedef enum logic [1:0] {
        ST_RUN        = 2'b00,
        ST_STORE_WAIT = 2'b01,
        ST_FLUSH      = 2'b10
    } commit_state_e;

endpackage

//--- source/store_wait_timer.sv
/*
 * Counts cycles a store spends waiting at the head; raises a sticky timeout.
 */
`timescale 1ns/1ns

module store_wait_timer #(
    parameter int STORE_TIMEOUT = 8
) (
    input  logic clk,
    input  logic arst_n,
    input  logic timer_run,
    output logic store_timeout
);
    localparam int CNT_W = $clog2(STORE_TIMEOUT + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STORE_TIMEOUT - 1);
    localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(STORE_TIMEOUT);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt           <= '0;
            store_timeout <= 1'b0;
        end else if (timer_run) begin
            // Saturate rather than wrap
            if (cnt != CNT_MAX) begin
                cnt <= cnt + 1'b1;
            end
            if (cnt == CNT_LAST) begin
                store_timeout <= 1'b1;
            end
        end else begin
            cnt <= '0;
        end
    end

endmodule
